//--- list.f
hw/rx_8b10b_pkg.sv
hw/rx_regs_pkg.sv
hw/rx_ifs.sv
hw/rx_stream_decoder.sv
hw/rx_record_fifo.sv
hw/rx_conf_regs.sv
hw/fei4_rx_top.sv
verif/tb_fei4_rx.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_fei4_rx -f list.f -o sim_tb_fei4_rx \
    || { echo "build failed"; exit 1; }
out="$(./obj_dir/sim_tb_fei4_rx 2>&1)"
echo "$out"
echo "$out" | grep -qx "Test completed successfully" && exit 0 || exit 1

//--- verif/tb_fei4_rx.sv
module tb_fei4_rx;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int         DEPTH   = 16;
    localparam logic [7:0] DATA_ID = 8'h01;
    localparam int         TIMEOUT = 400;
    localparam logic [9:0] COMMA_N = 10'b001111_1010; // K28.5, RD minus
    localparam logic [9:0] COMMA_P = 10'b110000_0101;
    localparam logic [9:0] BAD_SYM = 10'b000000_0000; // no valid 6b code
    // RD minus {abcdei,fghj} codes of D0.0, D21.5, D10.2, D3.3
    localparam logic [9:0] ENC_SYM [4] = '{10'b100111_0100, 10'b101010_1010,
                                           10'b010101_0101, 10'b110001_1100};
    localparam logic [7:0] ENC_BYTE [4] = '{8'h00, 8'hB5, 8'h4A, 8'h63};

    logic        BUS_CLK;
    logic        RST_FLAG;
    logic        rx_data;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic [7:0]  bus_data_out;
    logic        bus_wr;
    logic        bus_rd;
    logic        fifo_read;
    logic        fifo_empty;
    logic [31:0] fifo_data;
    logic        rx_ready;
    logic        rx_8b10b_decoder_err;
    logic        rx_fifo_overflow_err;
    logic        rx_fifo_full;
    logic        rx_enabled;

    int          errors;
    int          seed;
    int          exp_lost;  // records the model expects to be dropped
    logic        tx_invert; // line polarity on the sending side
    logic        tx_busy;
    logic        rx_off;    // window where the receiver must stay idle
    logic [31:0] exp_q[$];
    logic [9:0]  tx_q[$];

    fei4_rx_top #(.ABUSWIDTH(16), .FIFO_DEPTH(DEPTH), .DATA_IDENTIFIER(DATA_ID)) u_dut (.*);

    initial begin
        BUS_CLK = 1'b0;
        forever #5 BUS_CLK = ~BUS_CLK;
    end

    // serial line, idles with alternating commas between queued symbols
    initial begin : line_driver
        logic [9:0] sym;
        logic       pol;
        int         b;
        rx_data = 1'b0;
        tx_busy = 1'b0;
        pol     = 1'b0;
        forever begin
            if (tx_q.size() > 0) begin
                sym     = tx_q.pop_front();
                tx_busy = 1'b1;
            end else begin
                sym     = pol ? COMMA_P : COMMA_N;
                pol     = !pol;
                tx_busy = 1'b0;
            end
            for (b = 9; b >= 0; b--) begin // bit a first
                @(posedge BUS_CLK);
                rx_data <= sym[b] ^ tx_invert;
            end
        end
    end

    a_idle_when_off: assert property (@(posedge BUS_CLK) disable iff (RST_FLAG)
        rx_off |-> fifo_empty && !rx_ready) else begin
        errors++;
        $display("Receiver produced data or locked while disabled");
    end

    // lost count only grows on a strobe into a full FIFO, flag one cycle later
    a_ovf_needs_full: assert property (@(posedge BUS_CLK) disable iff (RST_FLAG)
        $rose(rx_fifo_overflow_err) |-> $past(rx_fifo_full, 2)) else begin
        errors++;
        $display("Overflow flag rose while the FIFO was not full");
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_flags(input logic rdy, input logic dec, input logic ovf,
                               input logic full, input logic empty);
        @(negedge BUS_CLK);
        check_val("rx_ready", rx_ready, rdy);
        check_val("rx_8b10b_decoder_err", rx_8b10b_decoder_err, dec);
        check_val("rx_fifo_overflow_err", rx_fifo_overflow_err, ovf);
        check_val("rx_fifo_full", rx_fifo_full, full);
        check_val("fifo_empty", fifo_empty, empty);
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        bus_add     <= addr;
        bus_data_in <= data;
        bus_wr      <= 1'b1;
        @(posedge BUS_CLK);
        bus_wr <= 1'b0;
    endtask

    task automatic read_expect(input logic [15:0] addr, input logic [7:0] exp, input string reg_name);
        @(posedge BUS_CLK);
        bus_add <= addr;
        bus_rd  <= 1'b1;
        @(posedge BUS_CLK);
        bus_rd <= 1'b0;
        @(negedge BUS_CLK); // data registered on the sampling edge
        check_val({"bus_data_out ", reg_name}, bus_data_out, exp);
    endtask

    task automatic wait_ready(input logic level);
        int n;
        n = 0;
        while (rx_ready !== level && n < TIMEOUT) begin
            @(negedge BUS_CLK);
            n++;
        end
        if (rx_ready !== level) begin
            errors++;
            $display("Timeout: rx_ready did not reach %0d", level);
        end
    endtask

    // rx reset write, FIFO and counters restart, then wait for a new lock
    task automatic rx_reset();
        bus_write(16'd1, 8'h00);
        exp_q.delete();
        exp_lost = 0;
        wait_ready(1'b0);
        wait_ready(1'b1);
    endtask

    task automatic send_record(input logic live);
        logic [23:0] rec;
        int          k;
        int          idx;
        rec = '0;
        for (k = 0; k < 3; k++) begin
            idx = $random(seed) & 3;
            rec = {rec[15:0], ENC_BYTE[idx]}; // first byte ends up on top
            tx_q.push_back(ENC_SYM[idx]);
        end
        if (live && exp_q.size() < DEPTH) begin
            exp_q.push_back({DATA_ID, rec});
        end else if (live) begin
            exp_lost++;
        end
    endtask

    task automatic run_stream(input int n_rec, input logic bad, input logic live);
        int r;
        int n;
        tx_q.push_back(COMMA_N);
        tx_q.push_back(COMMA_P);
        for (r = 0; r < n_rec; r++) begin
            if (bad && r == n_rec - 1) begin
                tx_q.push_back(ENC_SYM[1]); // partial record, dropped
                tx_q.push_back(ENC_SYM[2]);
                tx_q.push_back(BAD_SYM);
            end
            send_record(live);
        end
        tx_q.push_back(COMMA_N); // lets the last strobe land
        n = 0;
        while ((tx_q.size() > 0 || tx_busy) && n < 40 * n_rec + TIMEOUT) begin
            @(negedge BUS_CLK);
            n++;
        end
        if (tx_q.size() > 0 || tx_busy) begin
            errors++;
            $display("Timeout: serial stream did not finish");
        end
    endtask

    task automatic pop_expected();
        int n;
        while (exp_q.size() > 0) begin
            n = 0;
            @(negedge BUS_CLK);
            while (fifo_empty && n < TIMEOUT) begin
                @(negedge BUS_CLK);
                n++;
            end
            if (fifo_empty) begin
                errors++;
                $display("Timeout: FIFO empty with %0d records outstanding", exp_q.size());
                exp_q.delete();
            end else begin
                check_val("fifo_data", fifo_data, exp_q.pop_front());
                @(posedge BUS_CLK);
                fifo_read <= 1'b1;
                @(posedge BUS_CLK);
                fifo_read <= 1'b0;
            end
        end
        @(negedge BUS_CLK);
        check_val("rx_fifo_full", rx_fifo_full, 1'b0);
        check_val("fifo_empty", fifo_empty, 1'b1);
    endtask

    initial begin
        errors      = 0;
        seed        = 13753;
        exp_lost    = 0;
        tx_invert   = 1'b0;
        rx_off      = 1'b0;
        RST_FLAG    = 1'b1;
        bus_add     = '0;
        bus_data_in = '0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        fifo_read   = 1'b0;
        repeat (4) @(posedge BUS_CLK);
        RST_FLAG <= 1'b0;

        check_flags(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        check_val("rx_enabled", rx_enabled, 1'b0);
        read_expect(16'd0, 8'h03, "version");
        read_expect(16'd2, 8'h00, "status");

        rx_off <= 1'b1; // stream while disabled
        run_stream(4, 1'b0, 1'b0);
        rx_off <= 1'b0;
        bus_write(16'd2, 8'hA3);
        read_expect(16'd2, 8'hA2, "status"); // bit 0 is ready

        bus_write(16'd2, 8'h04);
        rx_reset();
        run_stream(4, 1'b0, 1'b1);
        read_expect(16'd2, 8'h05, "status");
        check_val("rx_enabled", rx_enabled, 1'b1);
        read_expect(16'd3, 8'(exp_q.size()), "size_lo");
        read_expect(16'd4, 8'h00, "size_hi");
        pop_expected();

        bus_write(16'd2, 8'h06); // invert on both ends
        tx_invert <= 1'b1;
        rx_reset();
        run_stream(3, 1'b1, 1'b1);
        read_expect(16'd5, 8'h01, "dec_err_cnt");
        check_flags(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        pop_expected();

        bus_write(16'd2, 8'hFC);
        tx_invert <= 1'b0;
        rx_reset();
        run_stream(DEPTH + 3, 1'b0, 1'b1);
        check_flags(1'b1, 1'b0, 1'b1, 1'b1, 1'b0);
        read_expect(16'd3, 8'(DEPTH), "size_lo");
        read_expect(16'd4, 8'h00, "size_hi");
        read_expect(16'd6, 8'(exp_lost), "lost_cnt");
        pop_expected();

        run_stream(DEPTH + 1, 1'b1, 1'b1);
        check_flags(1'b1, 1'b1, 1'b1, 1'b1, 1'b0);
        rx_reset();
        check_flags(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        read_expect(16'd5, 8'h00, "dec_err_cnt");
        read_expect(16'd6, 8'h00, "lost_cnt");
        read_expect(16'd3, 8'h00, "size_lo");
        read_expect(16'd2, 8'hFD, "status"); // bits 7:1 kept
        bus_write(16'd0, 8'h00);
        read_expect(16'd2, 8'h00, "status");
        check_flags(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        check_val("rx_enabled", rx_enabled, 1'b0);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- hw/fei4_rx_top.sv
module fei4_rx_top #(
    parameter int         ABUSWIDTH       = 16,
    parameter int         FIFO_DEPTH      = 16,
    parameter logic [7:0] DATA_IDENTIFIER = 8'h01
) (
    input  logic                 BUS_CLK,
    input  logic                 RST_FLAG,
    input  logic                 rx_data,
    input  logic [ABUSWIDTH-1:0] bus_add,
    input  logic [7:0]           bus_data_in,
    output logic [7:0]           bus_data_out,
    input  logic                 bus_wr,
    input  logic                 bus_rd,
    input  logic                 fifo_read,
    output logic                 fifo_empty,
    output logic [31:0]          fifo_data,
    output logic                 rx_ready,
    output logic                 rx_8b10b_decoder_err,
    output logic                 rx_fifo_overflow_err,
    output logic                 rx_fifo_full,
    output logic                 rx_enabled
);

    logic [23:0] record;
    logic        record_stb;

    rx_ctrl_if   ctrl_if ();
    fifo_stat_if stat_if ();

    assign rx_fifo_full = stat_if.full;

    rx_stream_decoder u_decoder (
        .BUS_CLK    (BUS_CLK),
        .RST_FLAG   (RST_FLAG),
        .rx_data    (rx_data),
        .ctrl       (ctrl_if.dec),
        .record     (record),
        .record_stb (record_stb)
    );

    rx_record_fifo #(
        .FIFO_DEPTH      (FIFO_DEPTH),
        .DATA_IDENTIFIER (DATA_IDENTIFIER)
    ) u_fifo (
        .BUS_CLK    (BUS_CLK),
        .RST_FLAG   (RST_FLAG),
        .record     (record),
        .record_stb (record_stb),
        .fifo_read  (fifo_read),
        .fifo_empty (fifo_empty),
        .fifo_data  (fifo_data),
        .stat       (stat_if.fifo)
    );

    rx_conf_regs #(
        .ABUSWIDTH (ABUSWIDTH)
    ) u_regs (
        .BUS_CLK              (BUS_CLK),
        .RST_FLAG             (RST_FLAG),
        .bus_add              (bus_add),
        .bus_data_in          (bus_data_in),
        .bus_wr               (bus_wr),
        .bus_rd               (bus_rd),
        .bus_data_out         (bus_data_out),
        .rx_ready             (rx_ready),
        .rx_8b10b_decoder_err (rx_8b10b_decoder_err),
        .rx_fifo_overflow_err (rx_fifo_overflow_err),
        .rx_enabled           (rx_enabled),
        .ctrl                 (ctrl_if.regs),
        .stat                 (stat_if.regs)
    );

endmodule

//--- hw/rx_conf_regs.sv
module rx_conf_regs import rx_regs_pkg::*; #(
    parameter int ABUSWIDTH = 16
) (
    input  logic                 BUS_CLK,
    input  logic                 RST_FLAG,
    input  logic [ABUSWIDTH-1:0] bus_add,
    input  logic [7:0]           bus_data_in,
    input  logic                 bus_wr,
    input  logic                 bus_rd,
    output logic [7:0]           bus_data_out,
    output logic                 rx_ready,
    output logic                 rx_8b10b_decoder_err,
    output logic                 rx_fifo_overflow_err,
    output logic                 rx_enabled,
    rx_ctrl_if.regs              ctrl,
    fifo_stat_if.regs            stat
);

    logic       soft_rst_wr;
    logic       rx_rst_wr;
    logic       rst_req;
    logic       rst_req_q;
    logic       clear;       // receiver and FIFO clear
    logic [7:1] status_q;    // bit 0 is the live ready flag
    logic [7:0] status_rd;
    logic [7:0] size_hi_q;

    assign soft_rst_wr = bus_wr && (bus_add == ABUSWIDTH'(ADDR_SOFT_RST));
    assign rx_rst_wr   = bus_wr && (bus_add == ABUSWIDTH'(ADDR_RX_RST));
    assign rst_req     = soft_rst_wr || rx_rst_wr;

    assign ctrl.enable = status_q[STAT_ENABLE];
    assign ctrl.invert = status_q[STAT_INVERT];
    assign ctrl.rx_rst = clear;
    assign stat.clear  = clear;
    assign rx_enabled  = status_q[STAT_ENABLE];

    always_comb begin
        status_rd             = {status_q, 1'b0};
        status_rd[STAT_READY] = ctrl.ready;
    end

    // rising edge of a reset write gives one pulse
    always_ff @(posedge BUS_CLK) begin
        if (RST_FLAG) begin
            rst_req_q <= 1'b0;
            clear     <= 1'b0;
        end else begin
            rst_req_q <= rst_req;
            clear     <= rst_req && !rst_req_q;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST_FLAG || soft_rst_wr) begin
            status_q <= '0; // receiver off
        end else if (bus_wr && bus_add == ABUSWIDTH'(ADDR_STATUS)) begin
            status_q <= bus_data_in[7:1];
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (bus_rd) begin
            case (bus_add)
                ABUSWIDTH'(ADDR_SOFT_RST): bus_data_out <= VERSION;
                ABUSWIDTH'(ADDR_STATUS):   bus_data_out <= status_rd;
                ABUSWIDTH'(ADDR_SIZE_LO):  bus_data_out <= stat.size[7:0];
                ABUSWIDTH'(ADDR_SIZE_HI):  bus_data_out <= size_hi_q;
                ABUSWIDTH'(ADDR_DEC_ERR):  bus_data_out <= ctrl.dec_err_cnt;
                ABUSWIDTH'(ADDR_LOST):     bus_data_out <= stat.lost_cnt;
                default:                   bus_data_out <= 8'h00;
            endcase
        end
    end

    // high byte snapshot so both halves belong to the same count
    always_ff @(posedge BUS_CLK) begin
        if (bus_rd && bus_add == ABUSWIDTH'(ADDR_SIZE_LO)) begin
            size_hi_q <= stat.size[15:8];
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST_FLAG) begin
            rx_ready             <= 1'b0;
            rx_8b10b_decoder_err <= 1'b0;
            rx_fifo_overflow_err <= 1'b0;
        end else begin
            rx_ready             <= ctrl.ready;
            rx_8b10b_decoder_err <= |ctrl.dec_err_cnt;
            rx_fifo_overflow_err <= |stat.lost_cnt;
        end
    end

    a_clear_single: assert property (
        @(posedge BUS_CLK) disable iff (RST_FLAG)
        clear |=> !clear
    ) else $error("clear pulse longer than one cycle");

endmodule

//--- hw/rx_record_fifo.sv
module rx_record_fifo #(
    parameter int         FIFO_DEPTH      = 16,
    parameter logic [7:0] DATA_IDENTIFIER = 8'h01
) (
    input  logic        BUS_CLK,
    input  logic        RST_FLAG,
    input  logic [23:0] record,
    input  logic        record_stb,
    input  logic        fifo_read,
    output logic        fifo_empty,
    output logic [31:0] fifo_data,
    fifo_stat_if.fifo   stat
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [23:0]   mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [15:0]   count;
    logic [7:0]    lost;
    logic          full;
    logic          push;
    logic          pop;

    assign full       = (count == 16'(FIFO_DEPTH));
    assign fifo_empty = (count == 16'd0);
    assign push       = record_stb && !full; // no back-pressure, excess is lost
    assign pop        = fifo_read && !fifo_empty;
    assign fifo_data  = {DATA_IDENTIFIER, mem[rd_ptr]}; // head word, fall through

    assign stat.size     = count;
    assign stat.full     = full;
    assign stat.lost_cnt = lost;

    always_ff @(posedge BUS_CLK) begin
        if (RST_FLAG || stat.clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 16'd1;
                2'b01:   count <= count - 16'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (push) begin
            mem[wr_ptr] <= record;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST_FLAG || stat.clear) begin
            lost <= '0;
        end else if (record_stb && full && lost != 8'hff) begin
            lost <= lost + 8'd1;
        end
    end

    a_size_bound: assert property (
        @(posedge BUS_CLK) disable iff (RST_FLAG)
        stat.size <= 16'(FIFO_DEPTH)
    ) else $error("FIFO size above depth");

endmodule

//--- hw/rx_stream_decoder.sv
module rx_stream_decoder import rx_8b10b_pkg::*; (
    input  logic        BUS_CLK,
    input  logic        RST_FLAG,
    input  logic        rx_data,
    rx_ctrl_if.dec      ctrl,
    output logic [23:0] record,
    output logic        record_stb
);

    logic        bit_in;      // polarity corrected
    sym_t        window;
    sym_t        next_window; // window including the current bit
    logic        is_comma;
    logic [3:0]  bit_cnt;     // bit position inside the symbol
    logic [1:0]  byte_cnt;    // data bytes of the partial record
    logic [15:0] rec_hold;
    logic        ready;
    logic [7:0]  err_cnt;
    logic        sym_done;    // tenth bit of an aligned symbol
    logic        data_byte;
    dec_result_t dec;

    assign bit_in      = rx_data ^ ctrl.invert;
    assign next_window = {window[8:0], bit_in};
    assign is_comma    = (next_window == K28_5_NEG) || (next_window == K28_5_POS);
    assign sym_done    = ctrl.enable && ready && (bit_cnt == 4'd9);
    assign dec         = decode_symbol(next_window);
    assign data_byte   = sym_done && !dec.err && !dec.k;

    assign ctrl.ready       = ready;
    assign ctrl.dec_err_cnt = err_cnt;

    // comma search, then fixed 10-bit framing
    always_ff @(posedge BUS_CLK) begin
        if (RST_FLAG || ctrl.rx_rst) begin
            window  <= '0;
            ready   <= 1'b0;
            bit_cnt <= '0;
        end else if (ctrl.enable) begin
            window <= next_window;
            if (!ready) begin
                if (is_comma) begin
                    ready   <= 1'b1;
                    bit_cnt <= '0; // next bit starts a symbol
                end
            end else if (bit_cnt == 4'd9) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // record framing and error count
    always_ff @(posedge BUS_CLK) begin
        if (RST_FLAG || ctrl.rx_rst) begin
            byte_cnt   <= '0;
            err_cnt    <= '0;
            record_stb <= 1'b0;
        end else begin
            record_stb <= 1'b0;
            if (ctrl.enable && !ready && is_comma) begin
                byte_cnt <= '0;
            end else if (sym_done) begin
                if (dec.err) begin
                    byte_cnt <= '0; // partial record is dropped
                    if (err_cnt != 8'hff) begin
                        err_cnt <= err_cnt + 8'd1;
                    end
                end else if (dec.k) begin
                    byte_cnt <= '0;
                end else if (byte_cnt == 2'd2) begin
                    byte_cnt   <= '0;
                    record_stb <= 1'b1;
                end else begin
                    byte_cnt <= byte_cnt + 2'd1;
                end
            end
        end
    end

    // first byte ends up in the top of the record
    always_ff @(posedge BUS_CLK) begin
        if (data_byte) begin
            if (byte_cnt == 2'd2) begin
                record <= {rec_hold, dec.data};
            end else begin
                rec_hold <= {rec_hold[7:0], dec.data};
            end
        end
    end

    // no record leaves while the receiver is disabled
    a_stb_needs_enable: assert property (
        @(posedge BUS_CLK) disable iff (RST_FLAG)
        record_stb |-> ctrl.enable
    ) else $error("record strobe while receiver disabled");

endmodule

//--- hw/rx_ifs.sv
// receiver control and status
interface rx_ctrl_if;
    logic       enable;
    logic       invert;      // serial polarity swap
    logic       rx_rst;      // one cycle clear
    logic       ready;       // comma lock
    logic [7:0] dec_err_cnt; // saturating

    modport regs (
        output enable, invert, rx_rst,
        input  ready, dec_err_cnt
    );

    modport dec (
        input  enable, invert, rx_rst,
        output ready, dec_err_cnt
    );
endinterface

// record FIFO fill state
interface fifo_stat_if;
    logic [15:0] size;
    logic [7:0]  lost_cnt; // dropped records, saturating
    logic        full;
    logic        clear;

    modport regs (
        input  size, lost_cnt, full,
        output clear
    );

    modport fifo (
        output size, lost_cnt, full,
        input  clear
    );
endinterface

//--- hw/rx_regs_pkg.sv
package rx_regs_pkg;

    // register map
    localparam int unsigned ADDR_SOFT_RST = 0;
    localparam int unsigned ADDR_RX_RST   = 1;
    localparam int unsigned ADDR_STATUS   = 2;
    localparam int unsigned ADDR_SIZE_LO  = 3;
    localparam int unsigned ADDR_SIZE_HI  = 4; // latched on size low read
    localparam int unsigned ADDR_DEC_ERR  = 5;
    localparam int unsigned ADDR_LOST     = 6;

    // status register bits
    localparam int STAT_READY  = 0; // read only
    localparam int STAT_INVERT = 1;
    localparam int STAT_ENABLE = 2;

    localparam logic [7:0] VERSION = 8'd3; // returned at address 0

endpackage

//--- hw/rx_8b10b_pkg.sv
package rx_8b10b_pkg;

    typedef logic [9:0] sym_t; // {a,b,c,d,e,i,f,g,h,j}, bit a goes on the line first

    localparam sym_t K28_5_NEG = 10'b001111_1010; // comma with running disparity minus
    localparam sym_t K28_5_POS = 10'b110000_0101;

    typedef struct packed {
        logic [7:0] data; // HGF EDCBA
        logic       k;    // control symbol
        logic       err;  // not a valid code
    } dec_result_t;

    // 6b to 5b, result is {valid, EDCBA}
    function automatic logic [5:0] dec_6b(input logic [5:0] abcdei);
        logic [5:0] res;
        case (abcdei)
            6'b100111, 6'b011000: res = {1'b1, 5'd0};
            6'b011101, 6'b100010: res = {1'b1, 5'd1};
            6'b101101, 6'b010010: res = {1'b1, 5'd2};
            6'b110001:            res = {1'b1, 5'd3};
            6'b110101, 6'b001010: res = {1'b1, 5'd4};
            6'b101001:            res = {1'b1, 5'd5};
            6'b011001:            res = {1'b1, 5'd6};
            6'b111000, 6'b000111: res = {1'b1, 5'd7};
            6'b111001, 6'b000110: res = {1'b1, 5'd8};
            6'b100101:            res = {1'b1, 5'd9};
            6'b010101:            res = {1'b1, 5'd10};
            6'b110100:            res = {1'b1, 5'd11};
            6'b001101:            res = {1'b1, 5'd12};
            6'b101100:            res = {1'b1, 5'd13};
            6'b011100:            res = {1'b1, 5'd14};
            6'b010111, 6'b101000: res = {1'b1, 5'd15};
            6'b011011, 6'b100100: res = {1'b1, 5'd16};
            6'b100011:            res = {1'b1, 5'd17};
            6'b010011:            res = {1'b1, 5'd18};
            6'b110010:            res = {1'b1, 5'd19};
            6'b001011:            res = {1'b1, 5'd20};
            6'b101010:            res = {1'b1, 5'd21};
            6'b011010:            res = {1'b1, 5'd22};
            6'b111010, 6'b000101: res = {1'b1, 5'd23};
            6'b110011, 6'b001100: res = {1'b1, 5'd24};
            6'b100110:            res = {1'b1, 5'd25};
            6'b010110:            res = {1'b1, 5'd26};
            6'b110110, 6'b001001: res = {1'b1, 5'd27};
            6'b001110:            res = {1'b1, 5'd28};
            6'b101110, 6'b010001: res = {1'b1, 5'd29};
            6'b011110, 6'b100001: res = {1'b1, 5'd30};
            6'b101011, 6'b010100: res = {1'b1, 5'd31};
            6'b001111, 6'b110000: res = {1'b1, 5'd28}; // K28
            default:              res = 6'b0;
        endcase
        return res;
    endfunction

    // 4b to 3b, result is {valid, HGF}
    function automatic logic [3:0] dec_4b(input logic [3:0] fghj);
        logic [3:0] res;
        case (fghj)
            4'b1011, 4'b0100: res = {1'b1, 3'd0};
            4'b1001:          res = {1'b1, 3'd1};
            4'b0101:          res = {1'b1, 3'd2};
            4'b1100, 4'b0011: res = {1'b1, 3'd3};
            4'b1101, 4'b0010: res = {1'b1, 3'd4};
            4'b1010:          res = {1'b1, 3'd5};
            4'b0110:          res = {1'b1, 3'd6};
            4'b1110, 4'b0001: res = {1'b1, 3'd7};
            4'b0111, 4'b1000: res = {1'b1, 3'd7}; // alternate 7
            default:          res = 4'b0;
        endcase
        return res;
    endfunction

    function automatic dec_result_t decode_symbol(input sym_t s);
        dec_result_t r;
        logic [5:0]  lo;
        logic [3:0]  hi;
        logic [3:0]  fghj;
        logic        k28;
        k28  = (s[9:4] == 6'b001111) || (s[9:4] == 6'b110000);
        // K28 with positive disparity carries the complemented 4b code
        fghj = (s[9:4] == 6'b110000) ? ~s[3:0] : s[3:0];
        lo   = dec_6b(s[9:4]);
        hi   = dec_4b(fghj);
        r.data = {hi[2:0], lo[4:0]};
        r.k    = k28;
        r.err  = !lo[5] || !hi[3];
        return r;
    endfunction

endpackage
